//--- include/vdiv_defines.svh
// Sizing macros for the packed-SIMD divider; lane count must equal word width / 8
`ifndef VDIV_DEFINES_SVH
`define VDIV_DEFINES_SVH

// Operand and result word width in bits
`define VDIV_WORD_W 32

// One lane per byte position of the word
`define VDIV_LANES 4

// Restoring steps per operation, one per dividend bit
`define VDIV_ITER 32

// Result FIFO entries
`define VDIV_FIFO_DEPTH 4

`endif

//--- source/vdiv_pkg.sv
// Shared divider types; element widths are limited to 8, 16 and 32 bits
`default_nettype none

`include "vdiv_defines.svh"

package vdiv_pkg;

    typedef logic [`VDIV_WORD_W-1:0] word_t;
    typedef logic [`VDIV_WORD_W-1:0] lane_t;
    typedef logic [3:0]              tag_t;

    typedef enum logic [1:0] {
        EEW_8  = 2'd0,
        EEW_16 = 2'd1,
        EEW_32 = 2'd2
    } eew_e;

    typedef enum logic [1:0] {
        CORE_IDLE = 2'd0,
        CORE_RUN  = 2'd1,
        CORE_DONE = 2'd2
    } core_state_e;

    typedef struct packed {
        word_t dividend;
        word_t divisor;
        eew_e  eew;
        logic  is_signed;
        logic  want_rem;
        tag_t  tag;
    } vdiv_req_t;

    // Sign fixups applied after the unsigned divide
    typedef struct packed {
        logic neg_q;
        logic neg_r;
    } lane_meta_t;

    typedef struct packed {
        lane_t      [`VDIV_LANES-1:0] dvd;
        lane_t      [`VDIV_LANES-1:0] dsr;
        lane_meta_t [`VDIV_LANES-1:0] meta;
        eew_e                         eew;
        logic                         want_rem;
        tag_t                         tag;
    } vdiv_job_t;

    typedef struct packed {
        lane_t      [`VDIV_LANES-1:0] quo;
        lane_t      [`VDIV_LANES-1:0] rem;
        lane_meta_t [`VDIV_LANES-1:0] meta;
        eew_e                         eew;
        logic                         want_rem;
        tag_t                         tag;
    } vdiv_lres_t;

    typedef struct packed {
        word_t result;
        tag_t  tag;
    } vdiv_rsp_t;

    // Bits of a lane that belong to the element
    function automatic lane_t elem_mask(input eew_e eew);
        case (eew)
            EEW_8:   return lane_t'(32'h0000_00ff);
            EEW_16:  return lane_t'(32'h0000_ffff);
            default: return lane_t'(32'hffff_ffff);
        endcase
    endfunction

    // A lane carries an element only where one starts at its byte
    function automatic logic lane_active(input eew_e eew, input int lane);
        case (eew)
            EEW_8:   return 1'b1;
            EEW_16:  return (lane % 2) == 0;
            EEW_32:  return lane == 0;
            default: return 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- source/vdiv_operand_prep.sv
// Holds one request; job_o is combinational from the held request, inactive lanes are zero
`timescale 1ns/1ps
`default_nettype none

`include "vdiv_defines.svh"

module vdiv_operand_prep
    import vdiv_pkg::*;
(
    input  wire        clk_i,
    input  wire        async_rst_ni,

    input  logic       in_valid_i,
    output logic       in_ready_o,
    input  vdiv_req_t  in_req_i,

    output logic       job_valid_o,
    input  logic       job_ready_i,
    output vdiv_job_t  job_o
);

    logic      valid_q;
    vdiv_req_t req_q;

    assign in_ready_o  = ~valid_q | job_ready_i;
    assign job_valid_o = valid_q;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (in_valid_i && in_ready_o) begin
            valid_q <= 1'b1;
        end else if (job_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            req_q <= in_req_i;
        end
    end

    //////////////////////////////
    // Element extraction

    always_comb begin : extract
        lane_t mask;
        lane_t a;
        lane_t b;
        logic  sa;
        logic  sb;

        mask         = elem_mask(req_q.eew);
        job_o.eew      = req_q.eew;
        job_o.want_rem = req_q.want_rem;
        job_o.tag      = req_q.tag;

        for (int l = 0; l < `VDIV_LANES; l++) begin
            a  = (req_q.dividend >> (8 * l)) & mask;
            b  = (req_q.divisor >> (8 * l)) & mask;
            // Top bit of the element is its sign
            sa = req_q.is_signed & (|(a & ~(mask >> 1)));
            sb = req_q.is_signed & (|(b & ~(mask >> 1)));

            if (lane_active(req_q.eew, l)) begin
                job_o.dvd[l]        = sa ? ((lane_t'(0) - a) & mask) : a;
                job_o.dsr[l]        = sb ? ((lane_t'(0) - b) & mask) : b;
                job_o.meta[l].neg_r = sa;
                // Zero divisor keeps the raw all-ones quotient
                job_o.meta[l].neg_q = (sa ^ sb) & (|b);
            end else begin
                job_o.dvd[l]  = '0;
                job_o.dsr[l]  = '0;
                job_o.meta[l] = '0;
            end
        end
    end

    a_job_hold: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        job_valid_o && !job_ready_i |=> job_valid_o && $stable(job_o)
    );

endmodule

`default_nettype wire

//--- source/vdiv_core.sv
// One operation at a time; job_ready_o is high only when idle, a job takes VDIV_ITER cycles
`timescale 1ns/1ps
`default_nettype none

`include "vdiv_defines.svh"

module vdiv_core
    import vdiv_pkg::*;
(
    input  wire         clk_i,
    input  wire         async_rst_ni,

    input  logic        job_valid_i,
    output logic        job_ready_o,
    input  vdiv_job_t   job_i,

    output logic        lres_valid_o,
    input  logic        lres_ready_i,
    output vdiv_lres_t  lres_o
);

    localparam int unsigned CNT_W = $clog2(`VDIV_ITER + 1);
    localparam int unsigned W     = `VDIV_WORD_W;

    core_state_e                  state_q;
    logic       [CNT_W-1:0]       cnt_q;
    // quo starts as the dividend and fills with quotient bits from the bottom
    vdiv_lres_t                   lres_q;
    lane_t      [`VDIV_LANES-1:0] dsr_q;
    lane_t      [`VDIV_LANES-1:0] quo_nxt;
    lane_t      [`VDIV_LANES-1:0] rem_nxt;

    assign job_ready_o  = (state_q == CORE_IDLE);
    assign lres_valid_o = (state_q == CORE_DONE);
    assign lres_o       = lres_q;

    //////////////////////////////
    // Restoring step

    always_comb begin : div_step
        logic [W:0] trial;
        logic [W:0] diff;

        for (int l = 0; l < `VDIV_LANES; l++) begin
            trial = {lres_q.rem[l], lres_q.quo[l][W-1]};
            diff  = trial - {1'b0, dsr_q[l]};
            if (diff[W]) begin
                rem_nxt[l] = trial[W-1:0];
                quo_nxt[l] = {lres_q.quo[l][W-2:0], 1'b0};
            end else begin
                rem_nxt[l] = diff[W-1:0];
                quo_nxt[l] = {lres_q.quo[l][W-2:0], 1'b1};
            end
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            state_q <= CORE_IDLE;
            cnt_q   <= '0;
        end else begin
            unique case (state_q)
                CORE_IDLE: begin
                    if (job_valid_i) begin
                        state_q <= CORE_RUN;
                        cnt_q   <= '0;
                    end
                end
                CORE_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (cnt_q == CNT_W'(`VDIV_ITER - 1)) begin
                        state_q <= CORE_DONE;
                    end
                end
                CORE_DONE: begin
                    if (lres_ready_i) begin
                        state_q <= CORE_IDLE;
                    end
                end
                default: state_q <= CORE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (job_valid_i && job_ready_o) begin
            lres_q.quo      <= job_i.dvd;
            lres_q.rem      <= '0;
            lres_q.meta     <= job_i.meta;
            lres_q.eew      <= job_i.eew;
            lres_q.want_rem <= job_i.want_rem;
            lres_q.tag      <= job_i.tag;
            dsr_q           <= job_i.dsr;
        end else if (state_q == CORE_RUN) begin
            lres_q.quo <= quo_nxt;
            lres_q.rem <= rem_nxt;
        end
    end

    a_cnt_bound: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        cnt_q <= CNT_W'(`VDIV_ITER)
    );

    // Result stays in DONE and unchanged until the FIFO takes it
    a_lres_hold: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        lres_valid_o && !lres_ready_i |=>
            lres_valid_o && (state_q == CORE_DONE) && $stable(lres_o)
    );

endmodule

`default_nettype wire

//--- source/vdiv_result_fifo.sv
// Synchronous FIFO, no bypass; a write is readable on the following cycle
`timescale 1ns/1ps
`default_nettype none

`include "vdiv_defines.svh"

module vdiv_result_fifo
    import vdiv_pkg::*;
(
    input  wire         clk_i,
    input  wire         async_rst_ni,

    input  logic        wr_valid_i,
    output logic        wr_ready_o,
    input  vdiv_lres_t  wr_data_i,

    output logic        rd_valid_o,
    input  logic        rd_ready_i,
    output vdiv_lres_t  rd_data_o
);

    localparam int unsigned DEPTH = `VDIV_FIFO_DEPTH;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    vdiv_lres_t             mem_q [DEPTH];
    logic       [PTR_W-1:0] wr_ptr_q;
    logic       [PTR_W-1:0] rd_ptr_q;
    logic       [CNT_W-1:0] count_q;
    logic                   wr_en;
    logic                   rd_en;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign wr_ready_o = (count_q != CNT_W'(DEPTH));
    assign rd_valid_o = (count_q != '0);
    assign rd_data_o  = mem_q[rd_ptr_q];
    assign wr_en      = wr_valid_i & wr_ready_o;
    assign rd_en      = rd_valid_o & rd_ready_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) wr_ptr_q <= ptr_inc(wr_ptr_q);
            if (rd_en) rd_ptr_q <= ptr_inc(rd_ptr_q);
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem_q[wr_ptr_q] <= wr_data_i;
        end
    end

    a_no_write_full: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        (count_q == CNT_W'(DEPTH)) |=> $stable(wr_ptr_q)
    );

    a_no_read_empty: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        (count_q == '0) |=> $stable(rd_ptr_q)
    );

endmodule

`default_nettype wire

//--- source/vdiv_result_compose.sv
// Registered output stage; result bytes outside active elements are driven as zero
`timescale 1ns/1ps
`default_nettype none

`include "vdiv_defines.svh"

module vdiv_result_compose
    import vdiv_pkg::*;
(
    input  wire         clk_i,
    input  wire         async_rst_ni,

    input  logic        lres_valid_i,
    output logic        lres_ready_o,
    input  vdiv_lres_t  lres_i,

    output logic        out_valid_o,
    input  logic        out_ready_i,
    output vdiv_rsp_t   out_rsp_o
);

    logic      out_valid_q;
    vdiv_rsp_t rsp_q;
    vdiv_rsp_t rsp_d;

    assign lres_ready_o = ~out_valid_q | out_ready_i;
    assign out_valid_o  = out_valid_q;
    assign out_rsp_o    = rsp_q;

    //////////////////////////////
    // Sign fixup and packing

    always_comb begin : compose
        lane_t mask;
        lane_t val;
        logic  neg;

        mask         = elem_mask(lres_i.eew);
        rsp_d.tag    = lres_i.tag;
        rsp_d.result = '0;

        for (int l = 0; l < `VDIV_LANES; l++) begin
            val = lres_i.want_rem ? lres_i.rem[l] : lres_i.quo[l];
            neg = lres_i.want_rem ? lres_i.meta[l].neg_r : lres_i.meta[l].neg_q;
            if (neg) begin
                val = lane_t'(0) - val;
            end
            if (lane_active(lres_i.eew, l)) begin
                // Element lands at its own byte offset
                rsp_d.result = rsp_d.result | word_t'((val & mask) << (8 * l));
            end
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            out_valid_q <= 1'b0;
        end else if (lres_valid_i && lres_ready_o) begin
            out_valid_q <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (lres_valid_i && lres_ready_o) begin
            rsp_q <= rsp_d;
        end
    end

    a_out_hold: assert property (
        @(posedge clk_i) disable iff (!async_rst_ni)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_rsp_o)
    );

endmodule

`default_nettype wire

//--- source/vdiv_top.sv
// Responses leave in request order; in_ready_o drops only while the unit is full
`timescale 1ns/1ps
`default_nettype none

module vdiv_top
    import vdiv_pkg::*;
(
    input  wire        clk_i,
    input  wire        async_rst_ni,

    input  logic       in_valid_i,
    output logic       in_ready_o,
    input  vdiv_req_t  in_req_i,

    output logic       out_valid_o,
    input  logic       out_ready_i,
    output vdiv_rsp_t  out_rsp_o
);

    logic       job_valid;
    logic       job_ready;
    vdiv_job_t  job;

    logic       lres_valid;
    logic       lres_ready;
    vdiv_lres_t lres;

    logic       fifo_valid;
    logic       fifo_ready;
    vdiv_lres_t fifo_data;

    vdiv_operand_prep u_prep (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .in_req_i     (in_req_i),
        .job_valid_o  (job_valid),
        .job_ready_i  (job_ready),
        .job_o        (job)
    );

    vdiv_core u_core (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .job_valid_i  (job_valid),
        .job_ready_o  (job_ready),
        .job_i        (job),
        .lres_valid_o (lres_valid),
        .lres_ready_i (lres_ready),
        .lres_o       (lres)
    );

    vdiv_result_fifo u_fifo (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .wr_valid_i   (lres_valid),
        .wr_ready_o   (lres_ready),
        .wr_data_i    (lres),
        .rd_valid_o   (fifo_valid),
        .rd_ready_i   (fifo_ready),
        .rd_data_o    (fifo_data)
    );

    vdiv_result_compose u_compose (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .lres_valid_i (fifo_valid),
        .lres_ready_o (fifo_ready),
        .lres_i       (fifo_data),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_rsp_o    (out_rsp_o)
    );

endmodule

`default_nettype wire

//--- verif/vdiv_tb.sv
// Run from the project root so the pattern file path resolves; stops at the first mismatch
`timescale 1ns/1ps
`default_nettype none

`include "vdiv_defines.svh"

module vdiv_tb
    import vdiv_pkg::*;
;

    typedef struct packed {
        word_t dividend;
        word_t divisor;
        eew_e  eew;
        logic  is_signed;
        logic  want_rem;
        word_t result;
    } pattern_t;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    logic      in_ready;
    vdiv_req_t in_req;
    logic      out_valid;
    logic      out_ready;
    vdiv_rsp_t out_rsp;

    pattern_t  pat_q[$];
    vdiv_rsp_t exp_q[$];
    int        num_pat;
    int        recv_cnt;
    logic      pat_loaded;

    vdiv_top dut0 (
        .clk_i        (clk),
        .async_rst_ni (rst_n),
        .in_valid_i   (in_valid),
        .in_ready_o   (in_ready),
        .in_req_i     (in_req),
        .out_valid_o  (out_valid),
        .out_ready_i  (out_ready),
        .out_rsp_o    (out_rsp)
    );

    always #20 clk = ~clk;

    //////////////////////////////
    // Failure handling

    task automatic fail_and_stop();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s got %h expected %h", $time, name, got, exp);
            fail_and_stop();
        end
    endtask

    //////////////////////////////
    // Pattern file

    task automatic load_patterns();
        int       fd;
        int       n;
        int       e;
        int       s;
        int       w;
        string    line;
        word_t    a;
        word_t    b;
        word_t    r;
        pattern_t p;

        fd = $fopen("verif/vdiv_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file verif/vdiv_patterns.txt");
            fail_and_stop();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // Skip blank lines and comment lines
                if (n > 0 && line.len() > 1 && line.substr(0, 1) != "//") begin
                    n = $sscanf(line, "%h %h %d %d %d %h", a, b, e, s, w, r);
                    if (n == 6) begin
                        p.dividend  = a;
                        p.divisor   = b;
                        p.eew       = eew_e'(2'(e));
                        p.is_signed = s[0];
                        p.want_rem  = w[0];
                        p.result    = r;
                        pat_q.push_back(p);
                    end
                end
            end
            $fclose(fd);
            num_pat = pat_q.size();
        end
    endtask

    //////////////////////////////
    // Driver and monitor

    task automatic send_requests();
        vdiv_rsp_t exp_rsp;

        for (int i = 0; i < num_pat; i++) begin
            in_valid           = 1'b1;
            in_req.dividend    = pat_q[i].dividend;
            in_req.divisor     = pat_q[i].divisor;
            in_req.eew         = pat_q[i].eew;
            in_req.is_signed   = pat_q[i].is_signed;
            in_req.want_rem    = pat_q[i].want_rem;
            in_req.tag         = tag_t'(i);
            exp_rsp.result     = pat_q[i].result;
            exp_rsp.tag        = tag_t'(i);
            exp_q.push_back(exp_rsp);
            @(posedge clk);
            while (!in_ready) begin
                // A stall needs the input register and the core both taken
                if (i - recv_cnt < 2) begin
                    $display("in_ready_o low at %0t ns with fewer than two requests in flight",
                             $time);
                    fail_and_stop();
                end
                @(posedge clk);
            end
            #2;
        end
        in_valid = 1'b0;
    endtask

    task automatic collect_responses();
        int        stall;
        vdiv_rsp_t exp_rsp;

        stall = 0;
        while (recv_cnt < num_pat) begin
            @(posedge clk);
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Response at %0t ns with no request outstanding", $time);
                    fail_and_stop();
                end else begin
                    exp_rsp = exp_q.pop_front();
                    check_value("out_rsp_o.tag", 32'(out_rsp.tag), 32'(exp_rsp.tag));
                    check_value("out_rsp_o.result", out_rsp.result, exp_rsp.result);
                    recv_cnt++;
                    // Mostly short gaps, now and then a long stall that fills the FIFO
                    if (($urandom % 5) == 0) begin
                        stall = 200 + $urandom % 100;
                    end else begin
                        stall = $urandom % 3;
                    end
                end
            end
            #2;
            if (stall > 0) begin
                out_ready = 1'b0;
                stall--;
            end else begin
                out_ready = 1'b1;
            end
        end
    endtask

    //////////////////////////////
    // Main sequence

    initial begin : main_seq
        int unsigned seed_val;

        seed_val   = $urandom(75083);
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_req     = '0;
        out_ready  = 1'b0;
        num_pat    = 0;
        recv_cnt   = 0;
        pat_loaded = 1'b0;

        load_patterns();
        pat_loaded = 1'b1;

        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_value("in_ready_o", 32'(in_ready), 32'd1);
        check_value("out_valid_o", 32'(out_valid), 32'd0);
        out_ready = 1'b1;

        fork
            send_requests();
            collect_responses();
        join

        if (num_pat > 0 && exp_q.size() == 0 && recv_cnt == num_pat) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("Pattern file empty or responses missing at the end of the run");
            fail_and_stop();
        end
    end

    initial begin : watchdog
        wait (pat_loaded);
        repeat (num_pat * (`VDIV_ITER + 8) * 4 + 10) @(posedge clk);
        $display("Timeout: not all responses arrived within the cycle limit");
        fail_and_stop();
    end

endmodule

`default_nettype wire

//--- verif/vdiv_patterns.txt
// dividend divisor eew(0=8,1=16,2=32) is_signed want_rem expected (hex words)
// Elements are packed at byte offsets; unused bytes of the result are zero
00000064 00000007 2 0 0 0000000e
00000064 00000007 2 0 1 00000002
ffffffff 00000010 2 0 0 0fffffff
12345678 00001000 2 0 0 00012345
12345678 00001000 2 0 1 00000678
123400ff 00100007 1 0 0 01230024
123400ff 00100007 1 0 1 00040003
ffff8000 00030100 1 0 0 55550080
c8640fff 0a070402 0 0 0 140e037f
c8640fff 0a070402 0 0 1 00020301
ffffff9c 00000007 2 1 0 fffffff2
ffffff9c 00000007 2 1 1 fffffffe
00000064 fffffff9 2 1 0 fffffff2
00000064 fffffff9 2 1 1 00000002
ffffff9c fffffff9 2 1 0 0000000e
fc1803e8 0007fff9 1 1 0 ff72ff72
fc1803e8 0007fff9 1 1 1 fffa0006
7f9c07f9 0af7fe02 0 1 0 0c0bfdfd
7f9c07f9 0af7fe02 0 1 1 07ff01ff
12345678 00000000 2 0 0 ffffffff
12345678 00000000 2 0 1 12345678
80000005 00000000 2 1 0 ffffffff
80000005 00000000 2 1 1 80000005
40302010 04030002 0 0 0 1010ff08
40302010 04030002 0 0 1 00002000
fffb0009 0000fffe 1 1 0 fffffffc
fffb0009 0000fffe 1 1 1 fffb0001
85f01180 00010300 0 1 0 fff005ff
85f01180 00010300 0 1 1 85000280
80000000 ffffffff 2 1 0 80000000
80000000 ffffffff 2 1 1 00000000
80008000 0002ffff 1 1 0 c0008000
80808080 ffffffff 0 1 0 80808080
80808080 ffffffff 0 1 1 00000000
80000000 ffffffff 2 0 0 00000000

//--- vdiv.f
+incdir+include
source/vdiv_pkg.sv
source/vdiv_operand_prep.sv
source/vdiv_core.sv
source/vdiv_result_fifo.sv
source/vdiv_result_compose.sv
source/vdiv_top.sv
verif/vdiv_tb.sv
